// ==== ooo_core.f ====
design/core_pkg.sv
design/dispatch_rename.sv
design/execute_cluster.sv
design/reorder_buffer.sv
design/commit_port.sv
design/ooo_core.sv
sim/ooo_core_asserts.sv
sim/tb_ooo_core.sv

// ==== sim/tb_ooo_core.sv ====
`timescale 1ns/1ps

module tb_ooo_core;

    import core_pkg::*;

    localparam int RAND_COUNT  = 48;   // Mixed opcodes
    localparam int MUL_GROUPS  = 4;    // Six instructions each
    localparam int SAME_COUNT  = 20;   // More than PHYS_REGS writes to r7
    localparam int STALL_COUNT = 16;   // Sent under slow commit ack
    localparam int TOTAL       = RAND_COUNT + MUL_GROUPS * 6 + SAME_COUNT + STALL_COUNT;
    localparam int TIMEOUT     = 200;  // Cycles allowed per wait
    localparam int DRAIN       = 20;   // Quiet cycles expected after the last commit

    logic        clock;
    logic        reset;
    logic        in_req;
    logic        in_ack;
    inst_t       in_inst;
    logic        commit_req;
    logic        commit_ack;
    commit_t     commit_data;

    logic [31:0] rand_state  = 32'hdba2_4980;   // Instruction stream
    logic [31:0] delay_state = 32'hdba2_4980;   // Commit-side ack timing
    data_t       arch_regs [ARCH_REGS];   // Reference register state
    commit_t     expected [$];            // Commits still owed, program order

    ooo_core uut (
        .clock(clock), .reset(reset),
        .in_req(in_req), .in_ack(in_ack), .in_inst(in_inst),
        .commit_req(commit_req), .commit_ack(commit_ack), .commit_data(commit_data)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_rand(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic inst_t make_inst(input opcode_e op, input arch_reg_t dest,
                                        input arch_reg_t src1, input arch_reg_t src2,
                                        input data_t imm);
        inst_t inst;
        inst.opcode = op;
        inst.dest   = dest;
        inst.src1   = src1;
        inst.src2   = src2;
        inst.imm    = imm;
        return inst;
    endfunction

    function automatic inst_t random_inst();
        logic [31:0] r;
        r = next_rand(rand_state);
        // Upper bits of the LCG are the well mixed ones
        return make_inst(opcode_e'(3'(r[31:29] % 6)), r[28:26], r[25:23], r[22:20],
                         r[19:4]);
    endfunction

    // Architectural result of one instruction, sources read before dest write
    function automatic commit_t model_step(input inst_t inst);
        data_t   a;
        data_t   b;
        commit_t c;
        a = arch_regs[inst.src1];
        b = arch_regs[inst.src2];
        case (inst.opcode)
            op_add:  c.value = a + b;
            op_sub:  c.value = a - b;
            op_and:  c.value = a & b;
            op_xor:  c.value = a ^ b;
            op_li:   c.value = inst.imm;
            op_mul:  c.value = a * b;   // Wraps to XLEN
            default: c.value = 'x;
        endcase
        c.dest               = inst.dest;
        arch_regs[inst.dest] = c.value;
        return c;
    endfunction

    //////////////////////////////////////////////////
    // Handshake drivers
    //////////////////////////////////////////////////

    task automatic send_inst(input inst_t inst);
        int waited;
        expected.push_back(model_step(inst));
        in_inst = inst;
        in_req  = 1'b1;
        waited  = 0;
        while (!in_ack) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) abort_run("in_ack never rose for a pending request");
        end
        in_req = 1'b0;
        waited = 0;
        while (in_ack) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) abort_run("in_ack never fell after in_req dropped");
        end
    endtask

    task automatic take_commit(input logic slow);
        commit_t exp;
        int      waited;
        int      delay;
        waited = 0;
        while (!commit_req) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) abort_run("commit_req never rose");
        end
        assert (expected.size() != 0) else abort_run("Commit with no instruction outstanding");
        exp = expected.pop_front();
        assert (commit_data.dest == exp.dest)
        else abort_run($sformatf("Error: commit_data.dest = 0x%h, expected 0x%h",
                                 commit_data.dest, exp.dest));
        assert (commit_data.value == exp.value)
        else abort_run($sformatf("Error: commit_data.value = 0x%h, expected 0x%h",
                                 commit_data.value, exp.value));
        delay = slow ? 40 : int'(next_rand(delay_state) >> 30);   // Long hold lets the ROB fill
        repeat (delay) @(negedge clock);
        commit_ack = 1'b1;
        waited     = 0;
        while (commit_req) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) abort_run("commit_req never fell after commit_ack");
        end
        // Ack may linger after req drops
        delay = int'(next_rand(delay_state) >> 30);
        repeat (delay) @(negedge clock);
        commit_ack = 1'b0;
    endtask

    task automatic send_all();
        data_t   x;
        data_t   y;
        opcode_e op;
        repeat (RAND_COUNT) send_inst(random_inst());
        // Multiply, then independent and dependent ALU work right behind it
        repeat (MUL_GROUPS) begin
            x = data_t'(next_rand(rand_state) >> 9);
            y = data_t'(next_rand(rand_state) >> 11);
            send_inst(make_inst(op_li,  3'd1, 3'd0, 3'd0, x));
            send_inst(make_inst(op_li,  3'd2, 3'd0, 3'd0, y));
            send_inst(make_inst(op_mul, 3'd3, 3'd1, 3'd2, '0));
            send_inst(make_inst(op_xor, 3'd5, 3'd1, 3'd2, '0));   // Independent of the product
            send_inst(make_inst(op_add, 3'd4, 3'd3, 3'd1, '0));   // Needs the product
            send_inst(make_inst(op_sub, 3'd6, 3'd2, 3'd1, '0));
        end
        // Same dest over and over, forces physical register reuse
        send_inst(make_inst(op_li, 3'd7, 3'd0, 3'd0, 16'h0001));
        for (int i = 1; i < SAME_COUNT; i++) begin
            if (i % 2) op = op_add;
            else op = op_xor;
            send_inst(make_inst(op, 3'd7, 3'd7, arch_reg_t'(i % 7), '0));
        end
        // Their commits see slow acks
        repeat (STALL_COUNT) send_inst(random_inst());
    endtask

    // Bound checker failures end the run at once
    always @(negedge clock) begin
        if (uut.u_asserts.fail_count != 0) abort_run("A bound protocol assertion failed");
    end

    initial begin
        reset      = 1'b1;
        in_req     = 1'b0;
        in_inst    = '0;
        commit_ack = 1'b0;
        foreach (arch_regs[i]) arch_regs[i] = '0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        fork
            send_all();
            for (int n = 0; n < TOTAL; n++) begin
                take_commit(n >= TOTAL - STALL_COUNT);
            end
        join
        // Nothing may commit past the last instruction
        repeat (DRAIN) begin
            @(negedge clock);
            if (commit_req) abort_run("Commit appeared after every instruction had committed");
        end
        if (uut.u_asserts.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run("A bound protocol assertion failed");
        end
    end

endmodule

// ==== sim/ooo_core_asserts.sv ====
`timescale 1ns/1ps

module ooo_core_asserts (
    input logic                clock,
    input logic                reset,
    input logic                in_req,
    input logic                in_ack,
    input logic                commit_req,
    input logic                commit_ack,
    input core_pkg::commit_t   commit_data,
    input core_pkg::rob_cnt_t  rob_count    // Occupancy from inside the ROB
);

    import core_pkg::*;

    int unsigned fail_count = 0;   // Read by the testbench monitor

    //////////////////////////////////////////////////
    // Instruction handshake
    //////////////////////////////////////////////////

    // No pending request means ack cannot come up next cycle
    ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        !in_req && !in_ack |=> !in_ack)
    else begin
        $error("in_ack rose while in_req was low");
        fail_count++;
    end

    // Both outputs quiet right after a reset edge
    reset_quiet: assert property (@(posedge clock) reset |=> !in_ack && !commit_req)
    else begin
        $error("in_ack or commit_req high after reset");
        fail_count++;
    end

    //////////////////////////////////////////////////
    // Commit handshake and ROB
    //////////////////////////////////////////////////

    data_stable: assert property (@(posedge clock) disable iff (reset)
        commit_req && !commit_ack |=> $stable(commit_data))
    else begin
        $error("commit_data changed during an open request");
        fail_count++;
    end

    req_after_ack_low: assert property (@(posedge clock) disable iff (reset)
        commit_ack |=> !$rose(commit_req))
    else begin
        $error("commit_req rose while commit_ack was high");
        fail_count++;
    end

    rob_bound: assert property (@(posedge clock) disable iff (reset)
        rob_count <= rob_cnt_t'(ROB_DEPTH))   // Full buffer must block alloc
    else begin
        $error("ROB count exceeds its depth");
        fail_count++;
    end

endmodule

bind ooo_core ooo_core_asserts u_asserts (
    .clock(clock), .reset(reset), .in_req(in_req), .in_ack(in_ack),
    .commit_req(commit_req), .commit_ack(commit_ack), .commit_data(commit_data),
    .rob_count(u_rob.count_q)
);

// ==== design/ooo_core.sv ====
`timescale 1ns/1ps

module ooo_core (
    input  logic              clock,
    input  logic              reset,
    // Instruction handshake
    input  logic              in_req,
    output logic              in_ack,
    input  core_pkg::inst_t   in_inst,
    // Commit handshake
    output logic              commit_req,
    input  logic              commit_ack,
    output core_pkg::commit_t commit_data
);

    import core_pkg::*;

    //////////////////////////////////////////////////
    // Inter-block wires
    //////////////////////////////////////////////////

    logic       issue_valid;
    logic       issue_ready;
    renamed_t   issue_inst;
    logic       alloc_valid;
    rob_alloc_t alloc;
    rob_idx_t   rob_tail;
    logic       rob_full;
    complete_t  complete;       // Completion bus
    logic       free_valid;
    phys_reg_t  free_reg;
    logic       retire_valid;
    logic       retire_ready;
    commit_t    retire_data;

    // Input side
    dispatch_rename u_dispatch (
        .clock(clock), .reset(reset),
        .in_req(in_req), .in_ack(in_ack), .in_inst(in_inst),
        .issue_valid(issue_valid), .issue_ready(issue_ready), .issue_inst(issue_inst),
        .alloc_valid(alloc_valid), .alloc(alloc),
        .rob_tail(rob_tail), .rob_full(rob_full),
        .free_valid(free_valid), .free_reg(free_reg)
    );

    // Processing
    execute_cluster u_execute (
        .clock(clock), .reset(reset),
        .issue_valid(issue_valid), .issue_ready(issue_ready), .issue_inst(issue_inst),
        .complete(complete)
    );

    reorder_buffer u_rob (
        .clock(clock), .reset(reset),
        .alloc_valid(alloc_valid), .alloc(alloc),
        .rob_tail(rob_tail), .rob_full(rob_full),
        .complete(complete),
        .free_valid(free_valid), .free_reg(free_reg),
        .retire_valid(retire_valid), .retire_ready(retire_ready),
        .retire_data(retire_data)
    );

    // Output side
    commit_port u_commit (
        .clock(clock), .reset(reset),
        .retire_valid(retire_valid), .retire_ready(retire_ready),
        .retire_data(retire_data),
        .commit_req(commit_req), .commit_ack(commit_ack), .commit_data(commit_data)
    );

endmodule

// ==== design/commit_port.sv ====
`timescale 1ns/1ps

module commit_port (
    input  logic              clock,
    input  logic              reset,
    input  logic              retire_valid,
    output logic              retire_ready,
    input  core_pkg::commit_t retire_data,
    output logic              commit_req,
    input  logic              commit_ack,
    output core_pkg::commit_t commit_data
);

    import core_pkg::*;

    typedef enum logic [1:0] {
        cp_idle,       // Holding register empty
        cp_req,        // Request up, waiting for ack
        cp_wait_low    // Data taken, waiting for ack to drop
    } cp_state_e;

    cp_state_e state_q;
    commit_t   hold_q;

    assign retire_ready = (state_q == cp_idle);
    assign commit_req   = (state_q == cp_req);
    assign commit_data  = hold_q;   // Stable for the whole request

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= cp_idle;
        end else begin
            case (state_q)
                cp_idle:     if (retire_valid) state_q <= cp_req;
                cp_req:      if (commit_ack)   state_q <= cp_wait_low;
                cp_wait_low: if (!commit_ack)  state_q <= cp_idle;
                default:     state_q <= cp_idle;
            endcase
        end
    end

    // Capture the record as it retires
    always_ff @(posedge clock) begin
        if (retire_valid && retire_ready) begin
            hold_q <= retire_data;
        end
    end

endmodule

// ==== design/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                 clock,
    input  logic                 reset,
    // Allocation from rename
    input  logic                 alloc_valid,
    input  core_pkg::rob_alloc_t alloc,
    output core_pkg::rob_idx_t   rob_tail,
    output logic                 rob_full,
    // Completion from execute
    input  core_pkg::complete_t  complete,
    // Register release back to rename
    output logic                 free_valid,
    output core_pkg::phys_reg_t  free_reg,
    // Retire toward the commit port
    output logic                 retire_valid,
    input  logic                 retire_ready,
    output core_pkg::commit_t    retire_data
);

    import core_pkg::*;

    rob_alloc_t           entry_mem [ROB_DEPTH];   // Names per entry
    data_t                value_mem [ROB_DEPTH];   // Result per entry
    logic [ROB_DEPTH-1:0] done_q;                  // Result has arrived
    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    rob_cnt_t             count_q;
    logic                 head_done;
    logic                 retire_fire;

    //////////////////////////////////////////////////
    // Status and retire view
    //////////////////////////////////////////////////

    assign rob_tail  = tail_q;
    assign rob_full  = (count_q == rob_cnt_t'(ROB_DEPTH));
    assign head_done = (count_q != '0) && done_q[head_q];

    assign retire_valid = head_done;
    assign retire_fire  = head_done && retire_ready;   // Head leaves in order

    always_comb begin
        retire_data.dest  = entry_mem[head_q].arch_dest;
        retire_data.value = value_mem[head_q];
    end

    // Previous mapping is dead once its overwriter retires
    assign free_valid = retire_fire;
    assign free_reg   = entry_mem[head_q].old_pdest;

    //////////////////////////////////////////////////
    // Pointers and flags
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (alloc_valid) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + rob_idx_t'(1);   // Wraps at ROB_DEPTH
            end
            // Completion never targets the slot being allocated
            if (complete.valid) begin
                done_q[complete.rob_idx] <= 1'b1;
            end
            if (retire_fire) begin
                head_q <= head_q + rob_idx_t'(1);
            end
            case ({alloc_valid, retire_fire})
                2'b10:   count_q <= count_q + rob_cnt_t'(1);
                2'b01:   count_q <= count_q - rob_cnt_t'(1);
                default: count_q <= count_q;   // Both or neither
            endcase
        end
    end

    // Entry payload
    always_ff @(posedge clock) begin
        if (alloc_valid) begin
            entry_mem[tail_q] <= alloc;
        end
        if (complete.valid) begin
            value_mem[complete.rob_idx] <= complete.value;
        end
    end

endmodule

// ==== design/execute_cluster.sv ====
`timescale 1ns/1ps

module execute_cluster (
    input  logic                clock,
    input  logic                reset,
    input  logic                issue_valid,
    output logic                issue_ready,
    input  core_pkg::renamed_t  issue_inst,
    output core_pkg::complete_t complete
);

    import core_pkg::*;

    data_t                prf [PHYS_REGS];          // Physical register file
    logic [PHYS_REGS-1:0] ready_q;                  // Value present in prf
    complete_t            mult_pipe [MULT_STAGES-1];  // Stages ahead of write-back
    complete_t            mult_in;
    complete_t            wb;                       // Single write port this cycle
    complete_t            complete_q;
    data_t                op_a;
    data_t                op_b;
    data_t                alu_result;
    logic                 is_mul;
    logic                 src_ok;
    logic                 mult_done;                // Multiply writes back this edge
    logic                 issue_fire;

    // Operand read at issue
    assign op_a   = prf[issue_inst.psrc1];
    assign op_b   = prf[issue_inst.psrc2];
    assign is_mul = (issue_inst.opcode == op_mul);

    // li has no register sources
    assign src_ok = (issue_inst.opcode == op_li) ||
                    (ready_q[issue_inst.psrc1] && ready_q[issue_inst.psrc2]);

    assign mult_done = mult_pipe[MULT_STAGES-2].valid;

    // ALU would share the write port with a finishing multiply
    assign issue_ready = src_ok && !(mult_done && !is_mul);
    assign issue_fire  = issue_valid && issue_ready;

    //////////////////////////////////////////////////
    // ALU and multiplier front
    //////////////////////////////////////////////////

    always_comb begin
        case (issue_inst.opcode)
            op_add:  alu_result = op_a + op_b;
            op_sub:  alu_result = op_a - op_b;
            op_and:  alu_result = op_a & op_b;
            op_xor:  alu_result = op_a ^ op_b;
            op_li:   alu_result = issue_inst.imm;
            default: alu_result = '0;
        endcase
    end

    always_comb begin
        mult_in.valid   = issue_fire && is_mul;
        mult_in.rob_idx = issue_inst.rob_idx;
        mult_in.pdest   = issue_inst.pdest;
        mult_in.value   = op_a * op_b;   // Low XLEN bits of the product
    end

    // Write port select, multiply has priority
    always_comb begin
        wb = '0;
        if (mult_done) begin
            wb = mult_pipe[MULT_STAGES-2];
        end else if (issue_fire && !is_mul) begin
            wb.valid   = 1'b1;
            wb.rob_idx = issue_inst.rob_idx;
            wb.pdest   = issue_inst.pdest;
            wb.value   = alu_result;
        end
    end

    assign complete = complete_q;

    //////////////////////////////////////////////////
    // Register file, ready bits, pipe
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                prf[i] <= '0;
            end
            ready_q    <= {{(PHYS_REGS - ARCH_REGS){1'b0}}, {ARCH_REGS{1'b1}}};
            complete_q <= '0;
            for (int s = 0; s < MULT_STAGES - 1; s++) begin
                mult_pipe[s] <= '0;
            end
        end else begin
            if (issue_fire) begin
                ready_q[issue_inst.pdest] <= 1'b0;   // Producer now in flight
            end
            if (wb.valid) begin
                prf[wb.pdest]     <= wb.value;
                ready_q[wb.pdest] <= 1'b1;           // Overrides the clear for ALU ops
            end
            complete_q   <= wb;                      // Reported one cycle after write
            mult_pipe[0] <= mult_in;
            for (int s = 1; s < MULT_STAGES - 1; s++) begin
                mult_pipe[s] <= mult_pipe[s-1];
            end
        end
    end

endmodule

// ==== design/dispatch_rename.sv ====
`timescale 1ns/1ps

module dispatch_rename (
    input  logic                 clock,
    input  logic                 reset,
    // Four-phase instruction input
    input  logic                 in_req,
    output logic                 in_ack,
    input  core_pkg::inst_t      in_inst,
    // In-order issue toward execute
    output logic                 issue_valid,
    input  logic                 issue_ready,
    output core_pkg::renamed_t   issue_inst,
    // ROB allocation
    output logic                 alloc_valid,
    output core_pkg::rob_alloc_t alloc,
    input  core_pkg::rob_idx_t   rob_tail,
    input  logic                 rob_full,
    // Register released by retire
    input  logic                 free_valid,
    input  core_pkg::phys_reg_t  free_reg
);

    import core_pkg::*;

    phys_reg_t            map_q [ARCH_REGS];   // Arch -> phys map
    logic [PHYS_REGS-1:0] free_q;              // One bit per free phys reg
    logic [PHYS_REGS-1:0] free_d;
    phys_reg_t            free_pick;           // Lowest free index
    logic                 free_avail;
    logic                 in_ack_q;
    logic                 dispatch;            // Instruction leaves this cycle

    //////////////////////////////////////////////////
    // Free list pick
    //////////////////////////////////////////////////

    always_comb begin
        free_pick = '0;
        // Walk downward so the lowest set bit wins
        for (int i = PHYS_REGS - 1; i >= 0; i--) begin
            if (free_q[i]) begin
                free_pick = phys_reg_t'(i);
            end
        end
    end

    assign free_avail = |free_q;

    // Offer only a fresh request with room downstream
    assign issue_valid = in_req && !in_ack_q && free_avail && !rob_full;
    assign dispatch    = issue_valid && issue_ready;
    assign alloc_valid = dispatch;
    assign in_ack      = in_ack_q;

    // Rename lookup, purely combinational from the current map
    always_comb begin
        issue_inst.opcode  = in_inst.opcode;
        issue_inst.imm     = in_inst.imm;
        issue_inst.psrc1   = map_q[in_inst.src1];
        issue_inst.psrc2   = map_q[in_inst.src2];
        issue_inst.pdest   = free_pick;
        issue_inst.rob_idx = rob_tail;   // Slot the ROB fills this cycle

        alloc.arch_dest    = in_inst.dest;
        alloc.pdest        = free_pick;
        alloc.old_pdest    = map_q[in_inst.dest];   // Previous owner of dest
    end

    // Allocate and release in the same cycle
    always_comb begin
        free_d = free_q;
        if (dispatch) begin
            free_d[free_pick] = 1'b0;
        end
        if (free_valid) begin
            free_d[free_reg] = 1'b1;   // Freed reg never equals the pick
        end
    end

    //////////////////////////////////////////////////
    // State
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);   // Identity map
            end
            // Upper half of the pool starts free
            free_q   <= {{(PHYS_REGS - ARCH_REGS){1'b1}}, {ARCH_REGS{1'b0}}};
            in_ack_q <= 1'b0;
        end else begin
            free_q <= free_d;
            if (dispatch) begin
                map_q[in_inst.dest] <= free_pick;
            end
            // Ack rises with dispatch, falls once req is gone
            if (dispatch) begin
                in_ack_q <= 1'b1;
            end else if (!in_req) begin
                in_ack_q <= 1'b0;
            end
        end
    end

endmodule

// ==== design/core_pkg.sv ====
package core_pkg;

    //////////////////////////////////////////////////
    // Core sizes
    //////////////////////////////////////////////////

    localparam int XLEN        = 16;   // Datapath width
    localparam int ARCH_REGS   = 8;    // Architectural registers r0..r7
    localparam int PHYS_REGS   = 16;   // Rename pool
    localparam int ROB_DEPTH   = 8;    // In-flight window
    localparam int MULT_STAGES = 3;    // Multiply latency in cycles

    // Occupancy counter must hold 0..ROB_DEPTH inclusive
    localparam int ROB_CNT_W   = $clog2(ROB_DEPTH + 1);

    //////////////////////////////////////////////////
    // Scalar types
    //////////////////////////////////////////////////

    typedef logic [XLEN-1:0]                data_t;
    typedef logic [$clog2(ARCH_REGS)-1:0]   arch_reg_t;
    typedef logic [$clog2(PHYS_REGS)-1:0]   phys_reg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0]   rob_idx_t;
    typedef logic [ROB_CNT_W-1:0]           rob_cnt_t;

    // Decoded operation, already resolved before the core
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_xor = 3'd3,
        op_li  = 3'd4,   // dest = imm, sources ignored
        op_mul = 3'd5    // Goes to the multiplier pipe
    } opcode_e;

    //////////////////////////////////////////////////
    // Grouped signals between blocks
    //////////////////////////////////////////////////

    // Incoming instruction, architectural names
    typedef struct packed {
        opcode_e   opcode;
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;
        data_t     imm;      // Only meaningful for op_li
    } inst_t;

    // After rename, physical names plus its ROB slot
    typedef struct packed {
        opcode_e   opcode;
        data_t     imm;
        phys_reg_t psrc1;
        phys_reg_t psrc2;
        phys_reg_t pdest;    // Freshly allocated
        rob_idx_t  rob_idx;
    } renamed_t;

    // What the ROB keeps per entry for retire
    typedef struct packed {
        arch_reg_t arch_dest;
        phys_reg_t pdest;
        phys_reg_t old_pdest;   // Released when this entry retires
    } rob_alloc_t;

    // Write-back / completion bus, also used for multiplier stages
    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        phys_reg_t pdest;
        data_t     value;
    } complete_t;

    // Architectural result seen on the commit port
    typedef struct packed {
        arch_reg_t dest;
        data_t     value;
    } commit_t;

endpackage
